// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - logic/cpu_isa_pkg.sv
      - logic/cpu_bus_pkg.sv
      - logic/cpu_reg_slice.sv
      - logic/cpu_reg_write.sv
      - logic/cpu_reg_read.sv
      - logic/cpu_alu.sv
      - logic/cpu_control.sv
      - logic/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
`default_nettype none

module cpu_tb;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int mem_aw       = 10;
    localparam int mem_words    = 1 << mem_aw;
    localparam int alu_prog_len = 29;   // Instructions per ALU pair program
    localparam int num_fixed    = 3;
    localparam int num_random   = 8;
    localparam int num_nops     = 8;
    localparam int hold_cycles  = 10;
    localparam int num_runs     = num_fixed + num_random + 4;   // Programs, each with its own reset
    localparam int total_instrs = (num_nops + 1) + (num_fixed + num_random) * alu_prog_len
                                  + 15 + 22 + 3;
    localparam int timeout_cycles = total_instrs * 2 + num_runs * (reset_cycles + 2)
                                    + hold_cycles + 200;

    logic                    clock;
    logic                    arst_n;
    cpu_isa_pkg::data_word_t mem_rdata;
    cpu_bus_pkg::mem_req_t   mem_req;
    logic                    halted;

    cpu_isa_pkg::data_word_t mem [mem_words];
    cpu_isa_pkg::data_word_t prog [$];
    cpu_isa_pkg::data_word_t fetch_q [$];
    cpu_isa_pkg::data_word_t store_addr_q [$];
    cpu_isa_pkg::data_word_t store_data_q [$];
    cpu_isa_pkg::data_word_t exp_addr_q [$];
    cpu_isa_pkg::data_word_t exp_data_q [$];

    cpu_top cpu_top_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    always #(clk_period / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Memory model and watchdog
    ////////////////////////////////////////////////////////////

    assign mem_rdata = mem[mem_req.addr[mem_aw-1:0]];   // Same-cycle read

    always @(posedge clock)
    begin
        if (arst_n && mem_req.we)
        begin
            mem[mem_req.addr[mem_aw-1:0]] <= mem_req.wdata;
        end
    end

    initial
    begin
        #(timeout_cycles * clk_period);
        $display("Watchdog expired after %0d cycles before the tests finished", timeout_cycles);
        $display("TESTS FAILED");
        $fatal(1, "Run timed out");
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input cpu_isa_pkg::data_word_t expected,
                              input cpu_isa_pkg::data_word_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("ERROR at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // Request fields print as addr, wdata, we
    task automatic check_req(input string name, input cpu_bus_pkg::mem_req_t expected,
                             input cpu_bus_pkg::mem_req_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("ERROR at %0t: %s expected %h %h %b, actual %h %h %b",
                                $time, name, expected.addr, expected.wdata, expected.we,
                                actual.addr, actual.wdata, actual.we));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("ERROR at %0t: %s expected %b, actual %b",
                                $time, name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program building and running
    ////////////////////////////////////////////////////////////

    function automatic cpu_isa_pkg::data_word_t enc_reg(input cpu_isa_pkg::opcode_e op,
        input cpu_isa_pkg::reg_idx_t rd, input cpu_isa_pkg::reg_idx_t ra,
        input cpu_isa_pkg::reg_idx_t rb);
        cpu_isa_pkg::instr_t word;
        word                 = '0;
        word.reg_view.opcode = op;
        word.reg_view.rd     = rd;
        word.reg_view.ra     = ra;
        word.reg_view.rb     = rb;
        return word;
    endfunction

    function automatic cpu_isa_pkg::data_word_t enc_imm(input cpu_isa_pkg::opcode_e op,
        input cpu_isa_pkg::reg_idx_t rd, input cpu_isa_pkg::reg_idx_t ra,
        input logic [15:0] imm);
        cpu_isa_pkg::instr_t word;
        word                 = '0;
        word.imm_view.opcode = op;
        word.imm_view.rd     = rd;
        word.imm_view.ra     = ra;   // Flag register for brf
        word.imm_view.imm    = imm;
        return word;
    endfunction

    function automatic cpu_isa_pkg::data_word_t fill_word(input int unsigned addr);
        logic [15:0] a16;
        a16 = addr[15:0];
        return {~a16, a16};
    endfunction

    // Expected result of a register operation
    function automatic cpu_isa_pkg::data_word_t alu_model(input cpu_isa_pkg::opcode_e op,
        input cpu_isa_pkg::data_word_t a, input cpu_isa_pkg::data_word_t b);
        case (op)
            cpu_isa_pkg::op_add: return a + b;
            cpu_isa_pkg::op_sub: return a - b;
            cpu_isa_pkg::op_and: return a & b;
            cpu_isa_pkg::op_or:  return a | b;
            cpu_isa_pkg::op_xor: return a ^ b;
            cpu_isa_pkg::op_slt: return (a < b) ? 32'd1 : 32'd0;
            default:             return '0;
        endcase
    endfunction

    task automatic emit_const(input cpu_isa_pkg::reg_idx_t rd,
                              input cpu_isa_pkg::data_word_t value);
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, rd, 3'd0, value[15:0]));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldh, rd, 3'd0, value[31:16]));
    endtask

    task automatic expect_store(input cpu_isa_pkg::data_word_t addr,
                                input cpu_isa_pkg::data_word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_words; i++)
        begin
            mem[i] = fill_word(i);
        end
        foreach (prog[i])
        begin
            mem[i] = prog[i];
        end
    endtask

    task automatic reset_core();
        @(negedge clock);
        arst_n = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        arst_n = 1'b1;
    endtask

    // Steps from a fetch cycle until halted, logging fetches and stores
    task automatic run_program();
        int   cycle;
        logic prev_we;
        cycle   = 0;
        prev_we = 1'b0;
        fetch_q.delete();
        store_addr_q.delete();
        store_data_q.delete();
        while (!halted)
        begin
            if (mem_req.we)
            begin
                if (prev_we)
                begin
                    abort_run("Store write enable stayed high for more than one cycle");
                end
                store_addr_q.push_back(mem_req.addr);
                store_data_q.push_back(mem_req.wdata);
            end
            else if (cycle % 2 == 0)
            begin
                fetch_q.push_back(mem_req.addr);
            end
            prev_we = mem_req.we;
            cycle++;
            @(negedge clock);
        end
    endtask

    task automatic compare_stores();
        if (store_addr_q.size() != exp_addr_q.size())
        begin
            abort_run($sformatf("Expected %0d stores but the core made %0d",
                                exp_addr_q.size(), store_addr_q.size()));
        end
        foreach (exp_addr_q[i])
        begin
            check_word($sformatf("store %0d address", i), exp_addr_q[i], store_addr_q[i]);
            check_word($sformatf("store %0d data", i), exp_data_q[i], store_data_q[i]);
        end
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic execute_alu_pair(input cpu_isa_pkg::data_word_t a,
                                    input cpu_isa_pkg::data_word_t b);
        cpu_isa_pkg::opcode_e    op;
        cpu_isa_pkg::data_word_t base;
        base = 32'h300;
        prog.delete();
        emit_const(3'd1, a);
        emit_const(3'd2, b);
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd6, 3'd0, 16'd1));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd7, 3'd0, base[15:0]));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_add, 3'd7, 3'd7, 3'd6));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd2));
        prog.push_back(enc_reg(cpu_isa_pkg::op_add, 3'd7, 3'd7, 3'd6));
        expect_store(base, a);
        expect_store(base + 1, b);
        for (int i = 0; i <= 5; i++)
        begin
            op = cpu_isa_pkg::opcode_e'(i);   // add through slt
            prog.push_back(enc_reg(op, 3'd3, 3'd1, 3'd2));
            prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd3));
            prog.push_back(enc_reg(cpu_isa_pkg::op_add, 3'd7, 3'd7, 3'd6));
            expect_store(base + 2 + i, alu_model(op, a, b));
        end
        prog.push_back(enc_reg(cpu_isa_pkg::op_halt, 3'd0, 3'd0, 3'd0));
        load_program();
        reset_core();
        run_program();
        compare_stores();
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_and_fetch();
        cpu_bus_pkg::mem_req_t exp_req;
        prog.delete();
        repeat (num_nops) prog.push_back(enc_reg(cpu_isa_pkg::opcode_e'(7'd12), 3'd1, 3'd2, 3'd3));
        prog.push_back(enc_reg(cpu_isa_pkg::op_halt, 3'd0, 3'd0, 3'd0));
        load_program();
        reset_core();
        exp_req.wdata = '0;
        exp_req.we    = 1'b0;
        for (int c = 0; c < 2 * num_nops; c++)
        begin
            exp_req.addr = c / 2;       // Two cycles per instruction
            check_req("mem_req", exp_req, mem_req);
            check_bit("halted", 1'b0, halted);
            @(negedge clock);
        end
        run_program();
    endtask

    task automatic imm_and_alu();
        execute_alu_pair(32'h1234_8765, 32'h0000_f00f);
        execute_alu_pair(32'h0000_0007, 32'h0000_0007);   // Zero difference, equal compare
        execute_alu_pair(32'h0000_0001, 32'hffff_ffff);   // Unsigned compare, carry out
    endtask

    task automatic load_and_store();
        prog.delete();
        emit_const(3'd2, 32'ha5a5_5a5a);
        emit_const(3'd4, 32'h0bad_f00d);
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd1, 3'd0, 16'h0300));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd3, 3'd0, 16'h0301));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd1, 3'd2));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd3, 3'd4));
        prog.push_back(enc_reg(cpu_isa_pkg::op_load, 3'd5, 3'd1, 3'd0));
        prog.push_back(enc_reg(cpu_isa_pkg::op_load, 3'd6, 3'd3, 3'd0));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd7, 3'd0, 16'h0310));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd5));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd1, 3'd0, 16'h0311));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd1, 3'd6));
        prog.push_back(enc_reg(cpu_isa_pkg::op_halt, 3'd0, 3'd0, 3'd0));
        expect_store(32'h300, 32'ha5a5_5a5a);
        expect_store(32'h301, 32'h0bad_f00d);
        expect_store(32'h310, 32'ha5a5_5a5a);
        expect_store(32'h311, 32'h0bad_f00d);
        load_program();
        reset_core();
        run_program();
        compare_stores();
    endtask

    task automatic flags_and_branch();
        int exp_pc [22];
        prog.delete();
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd1, 3'd0, 16'd5));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd2, 3'd0, 16'd9));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd7, 3'd0, 16'h0320));
        prog.push_back(enc_reg(cpu_isa_pkg::op_slt, 3'd3, 3'd1, 3'd2));      // Flag set
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd3, 16'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_slt, 3'd4, 3'd2, 3'd1));      // Flag clear
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd4, 16'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd2));
        prog.push_back(enc_reg(cpu_isa_pkg::op_sub, 3'd5, 3'd1, 3'd1));      // Zero result
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd5, 16'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd1));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd4, 3'd0, 16'd7));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldh, 3'd4, 3'd0, 16'd0));     // Merged word not zero
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd4, 16'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd4));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd0, 3'd0, 16'd0));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldh, 3'd0, 3'd0, 16'd1));
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd0, 16'd1));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd0));
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd3, 16'd2));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd7, 3'd3));
        prog.push_back(enc_reg(cpu_isa_pkg::op_halt, 3'd0, 3'd0, 3'd0));
        prog.push_back(enc_imm(cpu_isa_pkg::op_brf, 3'd0, 3'd5, 16'hfffd)); // Back to 21
        exp_pc = '{0, 1, 2, 3, 4, 6, 7, 8, 9, 10, 12, 13, 14, 15, 16, 17, 18, 19, 20, 23, 21, 22};
        expect_store(32'h320, 32'd9);
        expect_store(32'h320, 32'd7);
        expect_store(32'h320, 32'h0001_0000);
        expect_store(32'h320, 32'd1);
        load_program();
        reset_core();
        run_program();
        if (fetch_q.size() != 22)
        begin
            abort_run($sformatf("Expected 22 fetches but the core made %0d", fetch_q.size()));
        end
        foreach (exp_pc[i])
        begin
            check_word($sformatf("fetch %0d address", i), cpu_isa_pkg::data_word_t'(exp_pc[i]),
                       fetch_q[i]);
        end
        compare_stores();
    endtask

    task automatic random_alu();
        cpu_isa_pkg::data_word_t a;
        cpu_isa_pkg::data_word_t b;
        for (int i = 0; i < num_random; i++)
        begin
            a = $urandom();
            b = (i % 4 == 3) ? a : $urandom();
            execute_alu_pair(a, b);
        end
    endtask

    task automatic halt_holds();
        cpu_bus_pkg::mem_req_t exp_req;
        prog.delete();
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd1, 3'd0, 16'h0330));
        prog.push_back(enc_imm(cpu_isa_pkg::op_ldl, 3'd2, 3'd0, 16'h0055));
        prog.push_back(enc_reg(cpu_isa_pkg::op_halt, 3'd0, 3'd0, 3'd0));
        prog.push_back(enc_reg(cpu_isa_pkg::op_store, 3'd0, 3'd1, 3'd2));
        load_program();
        reset_core();
        repeat (6)
        begin
            check_bit("halted", 1'b0, halted);
            @(negedge clock);
        end
        exp_req.addr  = 32'd3;          // pc past the halt
        exp_req.wdata = '0;
        exp_req.we    = 1'b0;
        repeat (hold_cycles)
        begin
            check_bit("halted", 1'b1, halted);
            check_req("mem_req", exp_req, mem_req);
            @(negedge clock);
        end
        check_word("memory word 0x330", fill_word(32'h330), mem[32'h330]);
    endtask

    initial
    begin
        clock  = 1'b0;
        arst_n = 1'b0;
        void'($urandom(32'hcea8_5613));
        reset_and_fetch();
        imm_and_alu();
        load_and_store();
        flags_and_branch();
        random_alu();
        halt_holds();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/cpu_alu.sv ====
`default_nettype none

module cpu_alu (
    input  cpu_isa_pkg::instr_t     instr,
    input  cpu_bus_pkg::operands_t  ops,
    output cpu_isa_pkg::data_word_t result,
    output logic                    result_flag,
    output logic                    lo_en,
    output logic                    hi_en
);

    localparam int hw = cpu_isa_pkg::half_width;
    localparam int dw = cpu_isa_pkg::data_width;

    logic is_slt;

    ////////////////////////////////////////////////////////////
    // Register form
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        result = '0;
        is_slt = 1'b0;
        case (instr.reg_view.opcode)
            cpu_isa_pkg::op_add:
                result = ops.a_val + ops.b_val;
            cpu_isa_pkg::op_sub:
                result = ops.a_val - ops.b_val;
            cpu_isa_pkg::op_and:
                result = ops.a_val & ops.b_val;
            cpu_isa_pkg::op_or:
                result = ops.a_val | ops.b_val;
            cpu_isa_pkg::op_xor:
                result = ops.a_val ^ ops.b_val;
            cpu_isa_pkg::op_slt:
            begin
                result = {{(dw-1){1'b0}}, (ops.a_val < ops.b_val)};
                is_slt = 1'b1;
            end
            default:
            begin
            end
        endcase

        // Immediate form
        case (instr.imm_view.opcode)
            cpu_isa_pkg::op_ldl:
                result = {{(dw-hw){1'b0}}, instr.imm_view.imm};
            cpu_isa_pkg::op_ldh:
                result = {instr.imm_view.imm, {hw{1'b0}}};
            default:
            begin
            end
        endcase
    end

    // Only ldh leaves the low half alone
    always_comb
    begin
        lo_en = instr.imm_view.opcode != cpu_isa_pkg::op_ldh;
        hi_en = 1'b1;
    end

    // For ldh this is provisional; the write decode redoes it on the merged word
    assign result_flag = is_slt ? result[0] : (result == '0);

endmodule

`default_nettype wire

// ==== logic/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

    typedef struct packed {
        cpu_isa_pkg::data_word_t addr;
        cpu_isa_pkg::data_word_t wdata;
        logic                    we;     // Write when high, read otherwise
    } mem_req_t;

    typedef enum logic {
        st_fetch = 1'b0,
        st_exec  = 1'b1
    } core_state_e;

    ////////////////////////////////////////////////////////////
    // Register file traffic
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                    en;
        cpu_isa_pkg::reg_idx_t   rd;
        cpu_isa_pkg::data_word_t value;
        logic                    lo_en;
        logic                    hi_en;
        logic                    flag;
    } reg_wr_t;

    typedef struct packed {
        cpu_isa_pkg::data_word_t value;
        logic                    lo_en;
        logic                    hi_en;
        logic                    flag;
    } slice_wr_t;           // Shared by all slices

    typedef struct packed {
        cpu_isa_pkg::data_word_t a_val;
        cpu_isa_pkg::data_word_t b_val;
        logic                    a_flag;
    } operands_t;

endpackage

`default_nettype wire

// ==== logic/cpu_control.sv ====
`default_nettype none

module cpu_control (
    input  logic                    clock,
    input  logic                    arst_n,
    input  cpu_isa_pkg::data_word_t mem_rdata,
    output cpu_bus_pkg::mem_req_t   mem_req,
    input  cpu_bus_pkg::operands_t  ops,
    input  cpu_isa_pkg::data_word_t result,
    input  logic                    result_flag,
    input  logic                    lo_en,
    input  logic                    hi_en,
    output cpu_isa_pkg::reg_idx_t   ra,
    output cpu_isa_pkg::reg_idx_t   rb,
    output cpu_isa_pkg::instr_t     instr,
    output cpu_bus_pkg::reg_wr_t    reg_wr,
    output logic                    halted
);

    localparam int hw = cpu_isa_pkg::half_width;
    localparam int dw = cpu_isa_pkg::data_width;

    cpu_bus_pkg::core_state_e state;
    cpu_isa_pkg::data_word_t  pc;
    cpu_isa_pkg::data_word_t  pc_next;
    cpu_isa_pkg::data_word_t  branch_off;
    cpu_isa_pkg::opcode_e     opcode;
    logic                     executing;

    assign opcode    = instr.reg_view.opcode;
    assign ra        = instr.reg_view.ra;
    assign rb        = instr.reg_view.rb;
    assign executing = (state == cpu_bus_pkg::st_exec) && !halted;

    assign branch_off = {{(dw-hw){instr.imm_view.imm[hw-1]}}, instr.imm_view.imm};

    always_comb
    begin
        pc_next = pc + 1'b1;
        if (opcode == cpu_isa_pkg::op_brf && ops.a_flag)
        begin
            pc_next = pc + 1'b1 + branch_off;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus request and write-back
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        mem_req.addr  = pc;           // Fetch address, held while halted
        mem_req.wdata = '0;
        mem_req.we    = 1'b0;
        reg_wr.en     = 1'b0;
        reg_wr.rd     = instr.reg_view.rd;
        reg_wr.value  = result;
        reg_wr.lo_en  = lo_en;
        reg_wr.hi_en  = hi_en;
        reg_wr.flag   = result_flag;
        if (executing)
        begin
            case (opcode)
                cpu_isa_pkg::op_add, cpu_isa_pkg::op_sub, cpu_isa_pkg::op_and,
                cpu_isa_pkg::op_or, cpu_isa_pkg::op_xor, cpu_isa_pkg::op_slt,
                cpu_isa_pkg::op_ldl, cpu_isa_pkg::op_ldh:
                    reg_wr.en = 1'b1;
                cpu_isa_pkg::op_load:
                begin
                    mem_req.addr = ops.a_val;
                    reg_wr.en    = 1'b1;
                    reg_wr.value = mem_rdata;
                    reg_wr.lo_en = 1'b1;
                    reg_wr.hi_en = 1'b1;
                    reg_wr.flag  = (mem_rdata == '0);
                end
                cpu_isa_pkg::op_store:
                begin
                    mem_req.addr  = ops.a_val;
                    mem_req.wdata = ops.b_val;
                    mem_req.we    = 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= cpu_bus_pkg::st_fetch;
            pc     <= '0;
            instr  <= '0;
            halted <= 1'b0;
        end
        else if (state == cpu_bus_pkg::st_fetch)
        begin
            instr <= mem_rdata;
            state <= cpu_bus_pkg::st_exec;
        end
        else if (!halted)
        begin
            pc <= pc_next;
            if (opcode == cpu_isa_pkg::op_halt)
            begin
                halted <= 1'b1;       // Stay in exec for good
            end
            else
            begin
                state <= cpu_bus_pkg::st_fetch;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Word and register file sizes
    ////////////////////////////////////////////////////////////

    localparam int data_width = 32;
    localparam int half_width = data_width / 2;
    localparam int num_regs   = 8;
    localparam int idx_width  = $clog2(num_regs);
    localparam int op_width   = 7;

    typedef logic [data_width-1:0] data_word_t;
    typedef logic [idx_width-1:0]  reg_idx_t;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    typedef enum logic [op_width-1:0] {
        op_add   = 7'd0,
        op_sub   = 7'd1,
        op_and   = 7'd2,
        op_or    = 7'd3,
        op_xor   = 7'd4,
        op_slt   = 7'd5,  // Unsigned compare
        op_ldl   = 7'd6,
        op_ldh   = 7'd7,
        op_load  = 7'd8,
        op_store = 7'd9,
        op_brf   = 7'd10,
        op_halt  = 7'd11
    } opcode_e;             // Unlisted codes execute as no-ops

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [data_width-3*idx_width-op_width-1:0] unused;
        reg_idx_t rb;
        reg_idx_t ra;
        reg_idx_t rd;
        opcode_e  opcode;
    } instr_reg_t;

    typedef struct packed {
        logic [half_width-1:0]                             imm;
        logic [data_width-half_width-3*idx_width-op_width+idx_width-1:0] unused; // rb slot
        reg_idx_t ra;
        reg_idx_t rd;
        opcode_e  opcode;
    } instr_imm_t;

    // Same word, two views; opcode, rd and ra line up in both
    typedef union packed {
        instr_reg_t reg_view;
        instr_imm_t imm_view;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/cpu_reg_read.sv ====
`default_nettype none

module cpu_reg_read (
    input  cpu_isa_pkg::data_word_t          slice_values [cpu_isa_pkg::num_regs],
    input  logic [cpu_isa_pkg::num_regs-1:0] slice_flags,
    input  cpu_isa_pkg::reg_idx_t            ra,
    input  cpu_isa_pkg::reg_idx_t            rb,
    output cpu_bus_pkg::operands_t           ops
);

    ////////////////////////////////////////////////////////////
    // Operand A with its flag
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        ops.a_val  = '0;
        ops.a_flag = 1'b0;
        for (int i = 0; i < cpu_isa_pkg::num_regs; i++)
        begin
            if (ra == cpu_isa_pkg::reg_idx_t'(i))
            begin
                ops.a_val  = slice_values[i];
                ops.a_flag = slice_flags[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand B
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        ops.b_val = '0;
        for (int i = 0; i < cpu_isa_pkg::num_regs; i++)
        begin
            if (rb == cpu_isa_pkg::reg_idx_t'(i))
            begin
                ops.b_val = slice_values[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_reg_slice.sv ====
`default_nettype none

module cpu_reg_slice (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    wr_en,
    input  cpu_bus_pkg::slice_wr_t  wr,
    output cpu_isa_pkg::data_word_t value,
    output logic                    flag
);

    localparam int hw = cpu_isa_pkg::half_width;
    localparam int dw = cpu_isa_pkg::data_width;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            value <= '0;
            flag  <= 1'b0;
        end
        else if (wr_en)
        begin
            if (wr.lo_en)
            begin
                value[hw-1:0] <= wr.value[hw-1:0];
            end
            if (wr.hi_en)
            begin
                value[dw-1:hw] <= wr.value[dw-1:hw];
            end
            flag <= wr.flag;          // Already resolved for half writes
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_reg_write.sv ====
`default_nettype none

module cpu_reg_write (
    input  cpu_bus_pkg::reg_wr_t                  wr,
    input  cpu_isa_pkg::data_word_t               slice_values [cpu_isa_pkg::num_regs],
    output logic [cpu_isa_pkg::num_regs-1:0]      slice_en,
    output cpu_bus_pkg::slice_wr_t                slice_wr
);

    localparam int hw = cpu_isa_pkg::half_width;
    localparam int dw = cpu_isa_pkg::data_width;

    cpu_isa_pkg::data_word_t current;
    cpu_isa_pkg::data_word_t merged;
    logic                    full_write;

    // One-hot destination select
    always_comb
    begin
        for (int i = 0; i < cpu_isa_pkg::num_regs; i++)
        begin
            slice_en[i] = wr.en && (wr.rd == cpu_isa_pkg::reg_idx_t'(i));
        end
    end

    assign current    = slice_values[wr.rd];
    assign full_write = wr.lo_en && wr.hi_en;

    // Value the destination will hold after a half write
    always_comb
    begin
        merged = current;
        if (wr.lo_en)
        begin
            merged[hw-1:0] = wr.value[hw-1:0];
        end
        if (wr.hi_en)
        begin
            merged[dw-1:hw] = wr.value[dw-1:hw];
        end
    end

    always_comb
    begin
        slice_wr.value = wr.value;
        slice_wr.lo_en = wr.lo_en;
        slice_wr.hi_en = wr.hi_en;
        slice_wr.flag  = full_write ? wr.flag : (merged == '0);
    end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`default_nettype none

module cpu_top (
    input  logic                    clock,
    input  logic                    arst_n,
    input  cpu_isa_pkg::data_word_t mem_rdata,
    output cpu_bus_pkg::mem_req_t   mem_req,
    output logic                    halted
);

    cpu_bus_pkg::operands_t           ops;
    cpu_bus_pkg::reg_wr_t             reg_wr;
    cpu_bus_pkg::slice_wr_t           slice_wr;
    cpu_isa_pkg::instr_t              instr;
    cpu_isa_pkg::data_word_t          result;
    logic                             result_flag;
    logic                             lo_en;
    logic                             hi_en;
    cpu_isa_pkg::reg_idx_t            ra;
    cpu_isa_pkg::reg_idx_t            rb;
    logic [cpu_isa_pkg::num_regs-1:0] slice_en;
    logic [cpu_isa_pkg::num_regs-1:0] slice_flags;
    cpu_isa_pkg::data_word_t          slice_values [cpu_isa_pkg::num_regs];

    cpu_control cpu_control_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .ops         (ops),
        .result      (result),
        .result_flag (result_flag),
        .lo_en       (lo_en),
        .hi_en       (hi_en),
        .ra          (ra),
        .rb          (rb),
        .instr       (instr),
        .reg_wr      (reg_wr),
        .halted      (halted)
    );

    cpu_alu cpu_alu_inst (
        .instr       (instr),
        .ops         (ops),
        .result      (result),
        .result_flag (result_flag),
        .lo_en       (lo_en),
        .hi_en       (hi_en)
    );

    cpu_reg_write cpu_reg_write_inst (
        .wr           (reg_wr),
        .slice_values (slice_values),
        .slice_en     (slice_en),
        .slice_wr     (slice_wr)
    );

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < cpu_isa_pkg::num_regs; i++)
    begin : gen_slice
        cpu_reg_slice cpu_reg_slice_inst (
            .clock  (clock),
            .arst_n (arst_n),
            .wr_en  (slice_en[i]),
            .wr     (slice_wr),
            .value  (slice_values[i]),
            .flag   (slice_flags[i])
        );
    end

    cpu_reg_read cpu_reg_read_inst (
        .slice_values (slice_values),
        .slice_flags  (slice_flags),
        .ra           (ra),
        .rb           (rb),
        .ops          (ops)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
logic/cpu_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/cpu_reg_slice.sv
logic/cpu_reg_write.sv
logic/cpu_reg_read.sv
logic/cpu_alu.sv
logic/cpu_control.sv
logic/cpu_top.sv
dv/cpu_tb.sv
